/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_pueo_turf_ctrl
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# Pass or fail comes from the simulator output
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(BUILD_DIR)

/* design/baud_tick_gen.sv */
`timescale 1ns/1ps

module baud_tick_gen #(
    parameter int STEP  = 82,
    parameter int WIDTH = 10
) (
    input  logic ps_clk,
    input  logic rst_n_i,
    output logic tick_o
);

    logic [WIDTH-1:0] acc_q;
    logic [WIDTH:0]   sum;
    logic             tick_q;

    // Carry out of the phase accumulator is the tick
    assign sum = {1'b0, acc_q} + (WIDTH+1)'(STEP);

    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            acc_q  <= '0;
            tick_q <= 1'b0;
        end else begin
            acc_q  <= sum[WIDTH-1:0];
            tick_q <= sum[WIDTH];
        end
    end

    assign tick_o = tick_q;

endmodule

/* design/crate_bridge_guard.sv */
`timescale 1ns/1ps
`include "turf_defines.svh"

module crate_bridge_guard (
    input  logic                 ps_clk,
    input  logic                 rst_n_i,
    turf_bridge_if.guard         br,
    input  turf_pkg::link_mask_t aurora_up_i,
    input  logic                 crate_req_i,
    input  logic [1:0]           crate_link_i,
    input  logic                 crate_resp_i,
    output logic                 crate_cmd_o,
    output logic                 crate_done_o,
    output logic                 crate_busy_o
);

    localparam int CNT_W = $clog2(`BRIDGE_TIMEOUT_CYCLES);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`BRIDGE_TIMEOUT_CYCLES - 1);
    localparam turf_pkg::link_mask_t LINK_ONE = {{(`NUM_TURFIO-1){1'b0}}, 1'b1};

    turf_pkg::bridge_state_t state_q;
    turf_pkg::bridge_type_t  req_type;
    logic [CNT_W-1:0]        cnt_q;
    logic [1:0]              link_q;
    logic                    cmd_q;
    logic                    done_q;
    logic                    busy_q;
    logic                    accept;
    logic                    go_cmd;
    logic                    go_bad;
    logic                    resp_seen;
    logic                    timed_out;
    turf_pkg::link_mask_t    invalid_set;
    turf_pkg::link_mask_t    timeout_set;
    turf_pkg::link_mask_t    invalid_q;
    turf_pkg::link_mask_t    timeout_q;

    // Requests while busy are dropped
    assign accept   = crate_req_i && !busy_q;
    assign req_type = turf_pkg::bridge_type_t'(br.bridge_sel[{crate_link_i, 1'b0} +: 2]);
    assign go_cmd   = (req_type == turf_pkg::BRIDGE_AURORA) && aurora_up_i[crate_link_i];
    assign go_bad   = (req_type != turf_pkg::BRIDGE_NONE) && !go_cmd;

    // Response window opens with the command cycle and lasts the full timeout
    assign resp_seen = (state_q == turf_pkg::BR_WAIT) && crate_resp_i;
    assign timed_out = (state_q == turf_pkg::BR_WAIT) && !crate_resp_i && (cnt_q == CNT_LAST);

    assign invalid_set = (accept && go_bad) ? (LINK_ONE << crate_link_i) : '0;
    assign timeout_set = timed_out ? (LINK_ONE << link_q) : '0;

    always_ff @(posedge ps_clk) begin
        if (accept) begin
            link_q <= crate_link_i;
        end
    end

    ////////////////////////////////////////
    // Access FSM
    ////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            state_q   <= turf_pkg::BR_IDLE;
            cnt_q     <= '0;
            cmd_q     <= 1'b0;
            done_q    <= 1'b0;
            busy_q    <= 1'b0;
            invalid_q <= '0;
            timeout_q <= '0;
        end else begin
            cmd_q  <= 1'b0;
            done_q <= 1'b0;
            // Busy drops together with done
            if (done_q) begin
                busy_q <= 1'b0;
            end
            case (state_q)
                turf_pkg::BR_IDLE: begin
                    if (accept) begin
                        busy_q <= 1'b1;
                        if (go_cmd) begin
                            cmd_q   <= 1'b1;
                            cnt_q   <= '0;
                            state_q <= turf_pkg::BR_WAIT;
                        end else begin
                            done_q <= 1'b1;
                        end
                    end
                end
                turf_pkg::BR_WAIT: begin
                    if (resp_seen || timed_out) begin
                        done_q  <= 1'b1;
                        state_q <= turf_pkg::BR_IDLE;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: state_q <= turf_pkg::BR_IDLE;
            endcase
            // Sticky flags, a new event beats a clear on the same cycle
            invalid_q <= (invalid_q & ~br.flags_clear) | invalid_set;
            timeout_q <= (timeout_q & ~br.flags_clear) | timeout_set;
        end
    end

    assign crate_cmd_o      = cmd_q;
    assign crate_done_o     = done_q;
    assign crate_busy_o     = busy_q;
    assign br.invalid_flags = invalid_q;
    assign br.timeout_flags = timeout_q;

endmodule

/* design/pueo_turf_ctrl.sv */
`timescale 1ns/1ps
`include "turf_defines.svh"

module pueo_turf_ctrl (
    input  logic                 ps_clk,
    input  logic                 rst_n_i,
    // Register port
    input  logic                 reg_rd_i,
    input  logic                 reg_wr_i,
    input  turf_pkg::reg_addr_t  reg_addr_i,
    input  turf_pkg::reg_data_t  reg_wdata_i,
    output turf_pkg::reg_data_t  reg_rdata_o,
    output logic                 reg_ack_o,
    // Crate access
    input  turf_pkg::link_mask_t aurora_up_i,
    input  logic                 crate_req_i,
    input  logic [1:0]           crate_link_i,
    input  logic                 crate_resp_i,
    output logic                 crate_cmd_o,
    output logic                 crate_done_o,
    output logic                 crate_busy_o,
    // GPO sources
    input  logic                 sync_ce_i,
    input  logic                 sync_d_i,
    input  logic                 run_ce_i,
    input  logic                 run_d_i,
    input  logic                 trig_ce_i,
    input  logic                 trig_d_i,
    input  logic                 pps_ce_i,
    input  logic                 pps_d_i,
    output logic                 tout_o,
    // EMIO pins
    input  turf_pkg::link_mask_t tio_resetb_i,
    output turf_pkg::link_mask_t tio_resetb_o,
    output turf_pkg::link_mask_t tio_resetb_oe_o,
    input  logic                 gps_timepulse1_i,
    input  logic                 pps_pulse_i,
    input  logic                 hsk_complete_i,
    input  logic                 hsk_irq_i,
    input  logic                 uart_irq_b_i,
    output logic                 gps_extint1_o,
    // Serial debug ticks
    output logic                 hsk_tick_o,
    output logic                 gps_tick_o
);

    logic               gpo_en;
    turf_pkg::gpo_src_t gpo_select;
    turf_pkg::emio_t    emio_in;
    turf_pkg::emio_t    emio_out;
    turf_pkg::emio_t    emio_tri;

    turf_bridge_if br_if ();

    ////////////////////////////////////////
    // EMIO mapping
    ////////////////////////////////////////

    assign emio_in = {tio_resetb_i, gps_timepulse1_i, pps_pulse_i, 7'd0,
                      hsk_complete_i, hsk_irq_i, uart_irq_b_i};
    // Top nibble drives the TURFIO resets
    assign tio_resetb_o    = emio_out[15:12];
    assign tio_resetb_oe_o = ~emio_tri[15:12];
    assign gps_extint1_o   = !emio_tri[9] && emio_out[9];

    turf_ctl_regs u_regs (
        .ps_clk       (ps_clk),
        .rst_n_i      (rst_n_i),
        .reg_rd_i     (reg_rd_i),
        .reg_wr_i     (reg_wr_i),
        .reg_addr_i   (reg_addr_i),
        .reg_wdata_i  (reg_wdata_i),
        .reg_rdata_o  (reg_rdata_o),
        .reg_ack_o    (reg_ack_o),
        .br           (br_if),
        .gpo_en_o     (gpo_en),
        .gpo_select_o (gpo_select),
        .emio_i_i     (emio_in),
        .emio_o_o     (emio_out),
        .emio_t_o     (emio_tri)
    );

    crate_bridge_guard u_guard (
        .ps_clk       (ps_clk),
        .rst_n_i      (rst_n_i),
        .br           (br_if),
        .aurora_up_i  (aurora_up_i),
        .crate_req_i  (crate_req_i),
        .crate_link_i (crate_link_i),
        .crate_resp_i (crate_resp_i),
        .crate_cmd_o  (crate_cmd_o),
        .crate_done_o (crate_done_o),
        .crate_busy_o (crate_busy_o)
    );

    // Housekeeping 16x, roughly 8 MHz from 100 MHz
    baud_tick_gen #(
        .STEP  (`HSK_TICK_STEP),
        .WIDTH (`HSK_TICK_WIDTH)
    ) u_hsk_tick (
        .ps_clk  (ps_clk),
        .rst_n_i (rst_n_i),
        .tick_o  (hsk_tick_o)
    );

    // GPS 16x at 38400 baud
    baud_tick_gen #(
        .STEP  (`GPS_TICK_STEP),
        .WIDTH (`GPS_TICK_WIDTH)
    ) u_gps_tick (
        .ps_clk  (ps_clk),
        .rst_n_i (rst_n_i),
        .tick_o  (gps_tick_o)
    );

    turf_gpo_mux u_gpo_mux (
        .ps_clk       (ps_clk),
        .rst_n_i      (rst_n_i),
        .gpo_en_i     (gpo_en),
        .gpo_select_i (gpo_select),
        .sync_ce_i    (sync_ce_i),
        .sync_d_i     (sync_d_i),
        .run_ce_i     (run_ce_i),
        .run_d_i      (run_d_i),
        .trig_ce_i    (trig_ce_i),
        .trig_d_i     (trig_d_i),
        .pps_ce_i     (pps_ce_i),
        .pps_d_i      (pps_d_i),
        .tout_o       (tout_o)
    );

endmodule

/* design/turf_bridge_if.sv */
`timescale 1ns/1ps

interface turf_bridge_if;

    // Bridge type per link, from the control register
    turf_pkg::bridge_sel_t bridge_sel;
    // Sticky status back from the guard
    turf_pkg::link_mask_t  timeout_flags;
    turf_pkg::link_mask_t  invalid_flags;
    // One-cycle clear, one bit per link
    turf_pkg::link_mask_t  flags_clear;

    modport regs (output bridge_sel, output flags_clear,
                  input timeout_flags, input invalid_flags);

    modport guard (input bridge_sel, input flags_clear,
                   output timeout_flags, output invalid_flags);

endinterface

/* design/turf_ctl_regs.sv */
`timescale 1ns/1ps
`include "turf_defines.svh"

module turf_ctl_regs (
    input  logic                ps_clk,
    input  logic                rst_n_i,
    input  logic                reg_rd_i,
    input  logic                reg_wr_i,
    input  turf_pkg::reg_addr_t reg_addr_i,
    input  turf_pkg::reg_data_t reg_wdata_i,
    output turf_pkg::reg_data_t reg_rdata_o,
    output logic                reg_ack_o,
    turf_bridge_if.regs         br,
    output logic                gpo_en_o,
    output turf_pkg::gpo_src_t  gpo_select_o,
    input  turf_pkg::emio_t     emio_i_i,
    output turf_pkg::emio_t     emio_o_o,
    output turf_pkg::emio_t     emio_t_o
);

    localparam turf_pkg::reg_data_t IDENT_WORD = `TURF_IDENT;
    localparam logic [15:0] FW_DATE = `TURF_FW_DATE;
    // Board flag, date, then major/minor/revision
    localparam turf_pkg::reg_data_t DATEVER_WORD = {`TURF_REV_B, FW_DATE[14:0],
                                                    `TURF_VER_MAJOR, `TURF_VER_MINOR,
                                                    `TURF_VER_REV};

    turf_pkg::reg_map_t    addr;
    turf_pkg::reg_data_t   rdata_d;
    turf_pkg::reg_data_t   rdata_q;
    logic                  ack_q;
    logic                  wr_brstat;
    turf_pkg::bridge_sel_t bridge_sel_q;
    logic                  gpo_en_q;
    turf_pkg::gpo_src_t    gpo_select_q;
    turf_pkg::emio_t       emio_o_q;
    turf_pkg::emio_t       emio_t_q;

    assign addr = turf_pkg::reg_map_t'(reg_addr_i);

    ////////////////////////////////////////
    // Read path
    ////////////////////////////////////////

    always_comb begin
        case (addr)
            turf_pkg::REG_IDENT:   rdata_d = IDENT_WORD;
            turf_pkg::REG_DATEVER: rdata_d = DATEVER_WORD;
            turf_pkg::REG_CTRL:    rdata_d = {20'd0, gpo_select_q, gpo_en_q, bridge_sel_q};
            turf_pkg::REG_BRSTAT:  rdata_d = {24'd0, br.timeout_flags, br.invalid_flags};
            turf_pkg::REG_EMIO_O:  rdata_d = {16'd0, emio_o_q};
            turf_pkg::REG_EMIO_T:  rdata_d = {16'd0, emio_t_q};
            turf_pkg::REG_EMIO_I:  rdata_d = {16'd0, emio_i_i};
            // Unmapped word reads as zero
            default:               rdata_d = '0;
        endcase
    end

    always_ff @(posedge ps_clk) begin
        if (reg_rd_i) begin
            rdata_q <= rdata_d;
        end
    end

    ////////////////////////////////////////
    // Write path
    ////////////////////////////////////////

    // Either status bit of a link clears both of its flags
    assign wr_brstat = reg_wr_i && (addr == turf_pkg::REG_BRSTAT);
    assign br.flags_clear = wr_brstat ?
                            (reg_wdata_i[`NUM_TURFIO-1:0] |
                             reg_wdata_i[2*`NUM_TURFIO-1:`NUM_TURFIO]) : '0;

    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            ack_q        <= 1'b0;
            bridge_sel_q <= '0;
            gpo_en_q     <= 1'b0;
            gpo_select_q <= turf_pkg::GPO_SYNC;
            emio_o_q     <= '0;
            // All EMIO pins start tri-stated
            emio_t_q     <= '1;
        end else begin
            ack_q <= reg_rd_i | reg_wr_i;
            if (reg_wr_i) begin
                case (addr)
                    turf_pkg::REG_CTRL: begin
                        bridge_sel_q <= reg_wdata_i[2*`NUM_TURFIO-1:0];
                        gpo_en_q     <= reg_wdata_i[8];
                        gpo_select_q <= turf_pkg::gpo_src_t'(reg_wdata_i[11:9]);
                    end
                    turf_pkg::REG_EMIO_O: emio_o_q <= reg_wdata_i[`EMIO_WIDTH-1:0];
                    turf_pkg::REG_EMIO_T: emio_t_q <= reg_wdata_i[`EMIO_WIDTH-1:0];
                    default: ;
                endcase
            end
        end
    end

    assign reg_rdata_o   = rdata_q;
    assign reg_ack_o     = ack_q;
    assign br.bridge_sel = bridge_sel_q;
    assign gpo_en_o      = gpo_en_q;
    assign gpo_select_o  = gpo_select_q;
    assign emio_o_o      = emio_o_q;
    assign emio_t_o      = emio_t_q;

endmodule

/* design/turf_defines.svh */
`ifndef TURF_DEFINES_SVH
`define TURF_DEFINES_SVH

// Identity word reads as ASCII "TURF"
`define TURF_IDENT      32'h54555246
`define TURF_VER_MAJOR  4'd0
`define TURF_VER_MINOR  4'd8
`define TURF_VER_REV    8'd0
// Only the low 15 bits reach the date/version word
`define TURF_FW_DATE    16'h0000
`define TURF_REV_B      1'b1

// 16x baud ticks from ps_clk
`define HSK_TICK_STEP   82
`define HSK_TICK_WIDTH  10
`define GPS_TICK_STEP   25
`define GPS_TICK_WIDTH  12

`define BRIDGE_TIMEOUT_CYCLES 64
`define NUM_TURFIO      4
`define REG_ADDR_WIDTH  3
`define REG_DATA_WIDTH  32
`define EMIO_WIDTH      16

`endif

/* design/turf_gpo_mux.sv */
`timescale 1ns/1ps

module turf_gpo_mux (
    input  logic               ps_clk,
    input  logic               rst_n_i,
    input  logic               gpo_en_i,
    input  turf_pkg::gpo_src_t gpo_select_i,
    input  logic               sync_ce_i,
    input  logic               sync_d_i,
    input  logic               run_ce_i,
    input  logic               run_d_i,
    input  logic               trig_ce_i,
    input  logic               trig_d_i,
    input  logic               pps_ce_i,
    input  logic               pps_d_i,
    output logic               tout_o
);

    logic sel_ce;
    logic sel_d;
    logic tout_q;

    always_comb begin
        sel_ce = 1'b0;
        sel_d  = 1'b0;
        case (gpo_select_i)
            turf_pkg::GPO_SYNC: begin
                sel_ce = sync_ce_i;
                sel_d  = sync_d_i;
            end
            turf_pkg::GPO_RUN: begin
                sel_ce = run_ce_i;
                sel_d  = run_d_i;
            end
            turf_pkg::GPO_TRIG: begin
                sel_ce = trig_ce_i;
                sel_d  = trig_d_i;
            end
            turf_pkg::GPO_PPS: begin
                sel_ce = pps_ce_i;
                sel_d  = pps_d_i;
            end
            // Unused codes never load, output holds
            default: ;
        endcase
    end

    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            tout_q <= 1'b0;
        end else if (!gpo_en_i) begin
            tout_q <= 1'b0;
        end else if (sel_ce) begin
            tout_q <= sel_d;
        end
    end

    assign tout_o = tout_q;

endmodule

/* design/turf_pkg.sv */
`include "turf_defines.svh"

package turf_pkg;

    ////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////

    typedef logic [`REG_ADDR_WIDTH-1:0]  reg_addr_t;
    typedef logic [`REG_DATA_WIDTH-1:0]  reg_data_t;
    typedef logic [`NUM_TURFIO-1:0]      link_mask_t;
    // Two bits per link, link 0 lowest
    typedef logic [2*`NUM_TURFIO-1:0]    bridge_sel_t;
    typedef logic [`EMIO_WIDTH-1:0]      emio_t;

    ////////////////////////////////////////
    // Enumerations
    ////////////////////////////////////////

    typedef enum logic [1:0] {
        BRIDGE_NONE   = 2'd0,
        BRIDGE_AURORA = 2'd1,
        BRIDGE_RSVD2  = 2'd2,
        BRIDGE_RSVD3  = 2'd3
    } bridge_type_t;

    typedef enum logic {
        BR_IDLE = 1'b0,
        BR_WAIT = 1'b1
    } bridge_state_t;

    // Codes 4 to 7 leave the output without a source
    typedef enum logic [2:0] {
        GPO_SYNC = 3'd0,
        GPO_RUN  = 3'd1,
        GPO_TRIG = 3'd2,
        GPO_PPS  = 3'd3
    } gpo_src_t;

    typedef enum logic [2:0] {
        REG_IDENT   = 3'd0,
        REG_DATEVER = 3'd1,
        REG_CTRL    = 3'd2,
        REG_BRSTAT  = 3'd3,
        REG_EMIO_O  = 3'd4,
        REG_EMIO_T  = 3'd5,
        REG_EMIO_I  = 3'd6
    } reg_map_t;

endpackage

/* sim.f */
+incdir+design
+incdir+test
design/turf_pkg.sv
design/turf_bridge_if.sv
design/turf_ctl_regs.sv
design/crate_bridge_guard.sv
design/baud_tick_gen.sv
design/turf_gpo_mux.sv
design/pueo_turf_ctrl.sv
test/tb_pueo_turf_ctrl.sv

/* test/turf_tb_model.svh */
`ifndef TURF_TB_MODEL_SVH
`define TURF_TB_MODEL_SVH

`include "turf_defines.svh"

// Crate access outcomes
localparam int OUT_NONE    = 0;
localparam int OUT_RESP    = 1;
localparam int OUT_TIMEOUT = 2;
localparam int OUT_INVALID = 3;

// Galois LFSR, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
        return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
endfunction

// Revision flag, 15 date bits, major, minor, revision
function automatic logic [31:0] datever_word();
    logic [15:0] date;
    date = `TURF_FW_DATE;
    return {`TURF_REV_B, date[14:0], `TURF_VER_MAJOR, `TURF_VER_MINOR, `TURF_VER_REV};
endfunction

function automatic logic [15:0] emio_in_word(input logic [3:0] resetb, input logic tp,
                                             input logic pps, input logic hc,
                                             input logic hirq, input logic uirq);
    return {resetb, tp, pps, 7'd0, hc, hirq, uirq};
endfunction

// Delay counts cycles from the command cycle to the response strobe
function automatic int bridge_outcome(input logic [7:0] sel, input logic [3:0] up,
                                      input logic [1:0] link, input int delay);
    logic [1:0] t;
    t = sel[{link, 1'b0} +: 2];
    if (t == 2'd0) begin
        return OUT_NONE;
    end
    if (t == 2'd1 && up[link]) begin
        return (delay < `BRIDGE_TIMEOUT_CYCLES) ? OUT_RESP : OUT_TIMEOUT;
    end
    return OUT_INVALID;
endfunction

// Cycle of the done pulse, counted from the request cycle
function automatic int done_cycle(input int kind, input int delay);
    if (kind == OUT_RESP) begin
        return delay + 2;
    end
    if (kind == OUT_TIMEOUT) begin
        return `BRIDGE_TIMEOUT_CYCLES + 1;
    end
    return 1;
endfunction

function automatic int tick_count(input int cycles, input int step, input int width);
    return (cycles * step) >> width;
endfunction

// Source order is sync, run, trig, pps
function automatic logic gpo_next(input logic q, input logic en, input logic [2:0] sel,
                                  input logic [3:0] ce, input logic [3:0] d);
    if (!en) begin
        return 1'b0;
    end
    if (sel < 3'd4 && ce[sel[1:0]]) begin
        return d[sel[1:0]];
    end
    return q;
endfunction

`endif

/* test/tb_pueo_turf_ctrl.sv */
`timescale 1ns/1ps
`include "turf_defines.svh"

module tb_pueo_turf_ctrl;

    `include "turf_tb_model.svh"

    localparam int N_REG    = 40;
    localparam int N_CRATE  = 64;
    localparam int N_GPO    = 8;
    localparam int GPO_LEN  = 24;
    localparam int TICK_RUN = 600;
    localparam int WATCH_CYCLES = 40 + N_REG * 10 + N_CRATE * (`BRIDGE_TIMEOUT_CYCLES + 12)
                                  + N_GPO * (GPO_LEN + 4) + TICK_RUN + 500;

    logic        ps_clk;
    logic        rst_n_i;
    logic        reg_rd_i;
    logic        reg_wr_i;
    logic [2:0]  reg_addr_i;
    logic [31:0] reg_wdata_i;
    logic [31:0] reg_rdata_o;
    logic        reg_ack_o;
    logic [3:0]  aurora_up_i;
    logic        crate_req_i;
    logic [1:0]  crate_link_i;
    logic        crate_resp_i;
    logic        crate_cmd_o;
    logic        crate_done_o;
    logic        crate_busy_o;
    logic        sync_ce_i;
    logic        sync_d_i;
    logic        run_ce_i;
    logic        run_d_i;
    logic        trig_ce_i;
    logic        trig_d_i;
    logic        pps_ce_i;
    logic        pps_d_i;
    logic        tout_o;
    logic [3:0]  tio_resetb_i;
    logic [3:0]  tio_resetb_o;
    logic [3:0]  tio_resetb_oe_o;
    logic        gps_timepulse1_i;
    logic        pps_pulse_i;
    logic        hsk_complete_i;
    logic        hsk_irq_i;
    logic        uart_irq_b_i;
    logic        gps_extint1_o;
    logic        hsk_tick_o;
    logic        gps_tick_o;

    // Model state
    logic [31:0] lfsr_q;
    logic [11:0] ctrl_m;
    logic [15:0] emio_o_m;
    logic [15:0] emio_t_m;
    logic [3:0]  inv_m;
    logic [3:0]  tmo_m;
    logic        tout_m;
    int          mismatch_errs = 0;
    int          other_errs = 0;
    logic        run_q = 1'b0;
    int          run_cycles = 0;
    int          hsk_ticks = 0;
    int          gps_ticks = 0;

    pueo_turf_ctrl dut0 (.*);

    initial ps_clk = 1'b0;
    always #4 ps_clk = ~ps_clk;

    // Tick counters run over every clock edge taken out of reset
    always @(posedge ps_clk) run_q = rst_n_i;

    always @(negedge ps_clk) begin
        if (run_q) begin
            run_cycles = run_cycles + 1;
            hsk_ticks = hsk_ticks + int'(hsk_tick_o);
            gps_ticks = gps_ticks + int'(gps_tick_o);
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            mismatch_errs++;
            $display("Mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        other_errs++;
        $display("Error at %0t: %s", $time, what);
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge ps_clk);
        #1;
    endtask

    task automatic reg_write(input logic [2:0] addr, input logic [31:0] data);
        reg_wr_i = 1'b1;
        reg_addr_i = addr;
        reg_wdata_i = data;
        next_cycle();
        reg_wr_i = 1'b0;
        if (reg_ack_o !== 1'b1) begin
            report_failure("no register ack one cycle after a write");
        end
    endtask

    task automatic reg_read(input logic [2:0] addr, input logic [31:0] exp, input string name);
        reg_rd_i = 1'b1;
        reg_addr_i = addr;
        next_cycle();
        reg_rd_i = 1'b0;
        if (reg_ack_o !== 1'b1) begin
            report_failure("no register ack one cycle after a read");
        end
        compare(name, reg_rdata_o, exp);
    endtask

    task automatic check_emio_pins();
        compare("tio_resetb_o", 32'(tio_resetb_o), 32'(emio_o_m[15:12]));
        compare("tio_resetb_oe_o", 32'(tio_resetb_oe_o), {28'd0, ~emio_t_m[15:12]});
        compare("gps_extint1_o", 32'(gps_extint1_o), 32'(!emio_t_m[9] && emio_o_m[9]));
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////

    task automatic reg_test();
        logic [1:0]  pick;
        logic [31:0] data;
        for (int i = 0; i < N_REG; i++) begin
            pick = 2'(rand_bits(2));
            data = rand_bits(32);
            if (pick == 2'd0) begin
                reg_write(turf_pkg::REG_CTRL, data);
                ctrl_m = data[11:0];
            end else if (pick == 2'd1) begin
                reg_write(turf_pkg::REG_EMIO_O, data);
                emio_o_m = data[15:0];
            end else begin
                reg_write(turf_pkg::REG_EMIO_T, data);
                emio_t_m = data[15:0];
            end
            check_emio_pins();
            reg_read(turf_pkg::REG_CTRL, {20'd0, ctrl_m}, "reg_rdata_o CTRL");
            reg_read(turf_pkg::REG_EMIO_O, {16'd0, emio_o_m}, "reg_rdata_o EMIO_O");
            reg_read(turf_pkg::REG_EMIO_T, {16'd0, emio_t_m}, "reg_rdata_o EMIO_T");
            tio_resetb_i = 4'(rand_bits(4));
            gps_timepulse1_i = rand_bits(1) != 0;
            pps_pulse_i = rand_bits(1) != 0;
            hsk_complete_i = rand_bits(1) != 0;
            hsk_irq_i = rand_bits(1) != 0;
            uart_irq_b_i = rand_bits(1) != 0;
            reg_read(turf_pkg::REG_EMIO_I,
                     {16'd0, emio_in_word(tio_resetb_i, gps_timepulse1_i, pps_pulse_i,
                                          hsk_complete_i, hsk_irq_i, uart_irq_b_i)},
                     "reg_rdata_o EMIO_I");
        end
        reg_read(3'd7, 32'd0, "reg_rdata_o unmapped");
    endtask

    task automatic crate_test();
        logic [31:0] data;
        logic [3:0]  up;
        logic [1:0]  link;
        logic [7:0]  clr;
        int          delay;
        int          kind;
        int          last;
        logic        waits;
        for (int i = 0; i < N_CRATE; i++) begin
            if (i % 2 == 0) begin
                data = rand_bits(12);
                reg_write(turf_pkg::REG_CTRL, data);
                ctrl_m = data[11:0];
            end
            // Links are up three times out of four
            up = 4'(rand_bits(4));
            aurora_up_i = up | 4'(rand_bits(4));
            link = 2'(rand_bits(2));
            delay = int'(rand_bits(7));
            kind = bridge_outcome(ctrl_m[7:0], aurora_up_i, link, delay);
            last = done_cycle(kind, delay);
            waits = (kind == OUT_RESP) || (kind == OUT_TIMEOUT);
            crate_req_i = 1'b1;
            crate_link_i = link;
            for (int n = 1; n <= last + 2; n++) begin
                next_cycle();
                compare("crate_cmd_o", 32'(crate_cmd_o), 32'(waits && n == 1));
                compare("crate_done_o", 32'(crate_done_o), 32'(n == last));
                compare("crate_busy_o", 32'(crate_busy_o), 32'(n <= last));
                // No register strobe here, so the ack stays low
                compare("reg_ack_o", 32'(reg_ack_o), 32'd0);
                // A second request while busy must be dropped
                crate_req_i = (n == 1);
                if (n == 1) begin
                    crate_link_i = 2'(rand_bits(2));
                end
                crate_resp_i = waits && (n == delay + 1);
            end
            crate_req_i = 1'b0;
            crate_resp_i = 1'b0;
            if (kind == OUT_INVALID) begin
                inv_m[link] = 1'b1;
            end
            if (kind == OUT_TIMEOUT) begin
                tmo_m[link] = 1'b1;
            end
            reg_read(turf_pkg::REG_BRSTAT, {24'd0, tmo_m, inv_m}, "reg_rdata_o BRSTAT");
            if (rand_bits(1) != 0) begin
                clr = 8'(rand_bits(8));
                reg_write(turf_pkg::REG_BRSTAT, {24'd0, clr});
                // Either bit of a link clears both of its flags
                inv_m = inv_m & ~(clr[3:0] | clr[7:4]);
                tmo_m = tmo_m & ~(clr[3:0] | clr[7:4]);
                reg_read(turf_pkg::REG_BRSTAT, {24'd0, tmo_m, inv_m}, "reg_rdata_o BRSTAT");
            end
        end
    endtask

    task automatic gpo_test();
        logic [31:0] data;
        logic [3:0]  ce;
        logic [3:0]  d;
        for (int r = 0; r < N_GPO; r++) begin
            data = rand_bits(12);
            // Old enable still applies on the write edge
            tout_m = ctrl_m[8] ? tout_m : 1'b0;
            reg_write(turf_pkg::REG_CTRL, data);
            ctrl_m = data[11:0];
            for (int i = 0; i < GPO_LEN; i++) begin
                ce = 4'(rand_bits(4));
                d = 4'(rand_bits(4));
                {pps_ce_i, trig_ce_i, run_ce_i, sync_ce_i} = ce;
                {pps_d_i, trig_d_i, run_d_i, sync_d_i} = d;
                tout_m = gpo_next(tout_m, ctrl_m[8], ctrl_m[11:9], ce, d);
                next_cycle();
                compare("tout_o", 32'(tout_o), 32'(tout_m));
            end
            {pps_ce_i, trig_ce_i, run_ce_i, sync_ce_i} = 4'd0;
            {pps_d_i, trig_d_i, run_d_i, sync_d_i} = 4'd0;
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        lfsr_q = 32'h22d1716a;
        ctrl_m = '0;
        emio_o_m = '0;
        emio_t_m = '1;
        inv_m = '0;
        tmo_m = '0;
        tout_m = 1'b0;
        rst_n_i = 1'b0;
        reg_rd_i = 1'b0;
        reg_wr_i = 1'b0;
        reg_addr_i = '0;
        reg_wdata_i = '0;
        aurora_up_i = '0;
        crate_req_i = 1'b0;
        crate_link_i = '0;
        crate_resp_i = 1'b0;
        {pps_ce_i, trig_ce_i, run_ce_i, sync_ce_i} = 4'd0;
        {pps_d_i, trig_d_i, run_d_i, sync_d_i} = 4'd0;
        tio_resetb_i = '0;
        gps_timepulse1_i = 1'b0;
        pps_pulse_i = 1'b0;
        hsk_complete_i = 1'b0;
        hsk_irq_i = 1'b0;
        uart_irq_b_i = 1'b0;
        repeat (2) @(posedge ps_clk);
        #1;
        compare("reg_ack_o", 32'(reg_ack_o), 32'd0);
        compare("crate_cmd_o", 32'(crate_cmd_o), 32'd0);
        compare("crate_done_o", 32'(crate_done_o), 32'd0);
        compare("crate_busy_o", 32'(crate_busy_o), 32'd0);
        compare("hsk_tick_o", 32'(hsk_tick_o), 32'd0);
        compare("gps_tick_o", 32'(gps_tick_o), 32'd0);
        compare("tout_o", 32'(tout_o), 32'd0);
        check_emio_pins();
        rst_n_i = 1'b1;
        reg_read(turf_pkg::REG_IDENT, `TURF_IDENT, "reg_rdata_o IDENT");
        reg_read(turf_pkg::REG_DATEVER, datever_word(), "reg_rdata_o DATEVER");
        reg_read(turf_pkg::REG_CTRL, 32'd0, "reg_rdata_o CTRL");
        reg_read(turf_pkg::REG_BRSTAT, 32'd0, "reg_rdata_o BRSTAT");
        reg_read(turf_pkg::REG_EMIO_T, 32'h0000ffff, "reg_rdata_o EMIO_T");
        reg_test();
        crate_test();
        gpo_test();
        repeat (TICK_RUN) next_cycle();
        compare("hsk tick count", hsk_ticks,
                tick_count(run_cycles, `HSK_TICK_STEP, `HSK_TICK_WIDTH));
        compare("gps tick count", gps_ticks,
                tick_count(run_cycles, `GPS_TICK_STEP, `GPS_TICK_WIDTH));
        $display("Summary: %0d mismatches, %0d other errors", mismatch_errs, other_errs);
        if (mismatch_errs == 0 && other_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCH_CYCLES * 8);
        $display("Error: watchdog expired after %0d cycles, run did not finish", WATCH_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
